/* source/video_pkg.sv */
package video_pkg;

    // --------------------
    // pixel stream layout
    // --------------------

    // colour channels per pixel word
    localparam int CHANNELS = 3;

    // slice index inside the packed pixel, red sits in the low bits
    typedef enum int {
        CH_R = 0,
        CH_G = 1,
        CH_B = 2
    } channel_e;

    // --------------------
    // arithmetic
    // --------------------

    // contrast coefficient, unsigned fixed point
    localparam int COE_WIDTH = 9;

    // registers between video input and video output
    localparam int PIPE_LATENCY = 4;

endpackage

/* source/csr_pkg.sv */
package csr_pkg;

    // --------------------
    // wishbone bus
    // --------------------

    localparam int WB_ADDR_WIDTH = 4;
    localparam int WB_DATA_WIDTH = 32;

    // word address, taken from adr bits 3:2
    typedef enum logic [1:0] {
        REG_CONTRAST   = 2'd0,
        REG_BRIGHTNESS = 2'd1,
        REG_CTRL       = 2'd2
    } reg_addr_e;

    // --------------------
    // register contents
    // --------------------

    // unity gain with six fraction bits
    localparam int CONTRAST_RESET   = 64;
    localparam int BRIGHTNESS_RESET = 0;

    // ctrl register bit positions
    localparam int CTRL_BYPASS_BIT = 0;

endpackage

/* source/channel_contrast.sv */
`timescale 1ns/10ps

module channel_contrast
    import video_pkg::*;
#(
    parameter int PIXEL_WIDTH        = 8,
    parameter int COE_FRACTION_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [PIXEL_WIDTH-1:0] pix_i,
    input  logic [COE_WIDTH-1:0]   contrast_i,
    input  logic [PIXEL_WIDTH-1:0] brightness_i,
    output logic [PIXEL_WIDTH-1:0] pix_o
);

    // product width and signed sum width with headroom
    localparam int PROD_W  = COE_WIDTH + PIXEL_WIDTH;
    localparam int OFF_W   = PIXEL_WIDTH + 1 + COE_FRACTION_WIDTH;
    localparam int SUM_W   = PROD_W + 2;
    localparam int OVF_LSB = COE_FRACTION_WIDTH + PIXEL_WIDTH;

    // mid grey, 128 for 8-bit pixels
    localparam logic [OFF_W-1:0] MID = OFF_W'(1) << (PIXEL_WIDTH - 1);
    // half an output LSB
    localparam logic signed [SUM_W-1:0] ROUND_HALF = SUM_W'(1) << (COE_FRACTION_WIDTH - 1);

    logic [PROD_W-1:0]       prod_q;
    logic [PROD_W-1:0]       coe_mid_q;
    logic [OFF_W-1:0]        offset_q;
    logic signed [SUM_W-1:0] sum_q;
    logic signed [SUM_W-1:0] round_q;

    // --------------------
    // arithmetic stages
    // --------------------

    always_ff @(posedge clk) begin
        // stage 0, coefficients sampled together with the pixel
        prod_q    <= contrast_i * pix_i;
        coe_mid_q <= PROD_W'(contrast_i) << (PIXEL_WIDTH - 1);
        offset_q  <= (MID + OFF_W'(brightness_i)) << COE_FRACTION_WIDTH;

        // stage 1, contrast*(pix - mid) + (mid + brightness)
        sum_q <= $signed(SUM_W'(prod_q)) - $signed(SUM_W'(coe_mid_q))
               + $signed(SUM_W'(offset_q));

        // stage 2
        round_q <= sum_q + ROUND_HALF;
    end

    // --------------------
    // saturation
    // --------------------

    // stage 3, clamp then drop the fraction bits
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pix_o <= '0;
        end else if (round_q[SUM_W-1]) begin
            pix_o <= '0;
        end else if (|round_q[SUM_W-2:OVF_LSB]) begin
            pix_o <= '1;
        end else begin
            pix_o <= round_q[COE_FRACTION_WIDTH +: PIXEL_WIDTH];
        end
    end

endmodule

/* source/color_adjust_pipe.sv */
`timescale 1ns/10ps

module color_adjust_pipe
    import video_pkg::*;
#(
    parameter int PIXEL_WIDTH        = 8,
    parameter int COE_FRACTION_WIDTH = 6
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic [CHANNELS*PIXEL_WIDTH-1:0] pix_i,
    input  logic                            de_i,
    input  logic                            hs_i,
    input  logic                            vs_i,
    input  logic [COE_WIDTH-1:0]            contrast_i,
    input  logic [PIXEL_WIDTH-1:0]          brightness_i,
    input  logic                            bypass_i,
    output logic [CHANNELS*PIXEL_WIDTH-1:0] pix_o,
    output logic                            de_o,
    output logic                            hs_o,
    output logic                            vs_o
);

    logic [CHANNELS*PIXEL_WIDTH-1:0] adj_pix;
    logic [CHANNELS*PIXEL_WIDTH-1:0] raw_sr [PIPE_LATENCY];
    logic [PIPE_LATENCY-1:0]         de_sr;
    logic [PIPE_LATENCY-1:0]         hs_sr;
    logic [PIPE_LATENCY-1:0]         vs_sr;
    logic [PIPE_LATENCY-1:0]         bypass_sr;

    // one arithmetic pipeline per colour
    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel
        localparam channel_e CH_IDX = channel_e'(ch);
        channel_contrast #(
            .PIXEL_WIDTH        (PIXEL_WIDTH),
            .COE_FRACTION_WIDTH (COE_FRACTION_WIDTH)
        ) channel_contrast_inst (
            .clk          (clk),
            .rst_i        (rst_i),
            .pix_i        (pix_i[int'(CH_IDX)*PIXEL_WIDTH +: PIXEL_WIDTH]),
            .contrast_i   (contrast_i),
            .brightness_i (brightness_i),
            .pix_o        (adj_pix[int'(CH_IDX)*PIXEL_WIDTH +: PIXEL_WIDTH])
        );
    end

    // --------------------
    // matched delay lines
    // --------------------

    always_ff @(posedge clk) begin
        if (rst_i) begin
            de_sr     <= '0;
            hs_sr     <= '0;
            vs_sr     <= '0;
            bypass_sr <= '0;
        end else begin
            de_sr     <= {de_sr[PIPE_LATENCY-2:0], de_i};
            hs_sr     <= {hs_sr[PIPE_LATENCY-2:0], hs_i};
            vs_sr     <= {vs_sr[PIPE_LATENCY-2:0], vs_i};
            // bypass follows its own pixel
            bypass_sr <= {bypass_sr[PIPE_LATENCY-2:0], bypass_i};
        end
    end

    // raw pixel for the bypass path
    always_ff @(posedge clk) begin
        raw_sr[0] <= pix_i;
        for (int i = 1; i < PIPE_LATENCY; i++) begin
            raw_sr[i] <= raw_sr[i-1];
        end
    end

    assign pix_o = bypass_sr[PIPE_LATENCY-1] ? raw_sr[PIPE_LATENCY-1] : adj_pix;
    assign de_o  = de_sr[PIPE_LATENCY-1];
    assign hs_o  = hs_sr[PIPE_LATENCY-1];
    assign vs_o  = vs_sr[PIPE_LATENCY-1];

    // data enable lines up with the channel pipeline depth
    assert property (@(posedge clk) disable iff (rst_i)
        !$past(rst_i, PIPE_LATENCY) |-> de_o == $past(de_i, PIPE_LATENCY));

endmodule

/* source/adjust_csr.sv */
`timescale 1ns/10ps

module adjust_csr
    import video_pkg::*;
    import csr_pkg::*;
#(
    parameter int PIXEL_WIDTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [WB_ADDR_WIDTH-1:0]   wb_adr_i,
    input  logic [WB_DATA_WIDTH-1:0]   wb_dat_i,
    input  logic [WB_DATA_WIDTH/8-1:0] wb_sel_i,
    input  logic                       vs_i,
    output logic [WB_DATA_WIDTH-1:0]   wb_dat_o,
    output logic                       wb_ack_o,
    output logic [COE_WIDTH-1:0]       contrast_o,
    output logic [PIXEL_WIDTH-1:0]     brightness_o,
    output logic                       bypass_o
);

    logic                   req;
    reg_addr_e              reg_addr;
    logic [COE_WIDTH-1:0]   contrast_shadow;
    logic [PIXEL_WIDTH-1:0] brightness_shadow;
    logic                   bypass_shadow;
    logic                   vs_q;
    logic                   load_q;

    // replace only the byte lanes enabled by sel
    function automatic logic [WB_DATA_WIDTH-1:0] merge_lanes(
        input logic [WB_DATA_WIDTH-1:0]   old_val,
        input logic [WB_DATA_WIDTH-1:0]   new_val,
        input logic [WB_DATA_WIDTH/8-1:0] sel
    );
        logic [WB_DATA_WIDTH-1:0] merged;
        merged = old_val;
        for (int i = 0; i < WB_DATA_WIDTH / 8; i++) begin
            if (sel[i]) begin
                merged[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // new request only while ack is low, so each access acks once
    assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign reg_addr = reg_addr_e'(wb_adr_i[3:2]);

    // --------------------
    // bus side
    // --------------------

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_ack_o          <= 1'b0;
            contrast_shadow   <= COE_WIDTH'(CONTRAST_RESET);
            brightness_shadow <= PIXEL_WIDTH'(BRIGHTNESS_RESET);
            bypass_shadow     <= 1'b0;
        end else begin
            wb_ack_o <= req;
            if (req && wb_we_i) begin
                case (reg_addr)
                    REG_CONTRAST: contrast_shadow <= COE_WIDTH'(merge_lanes(
                        WB_DATA_WIDTH'(contrast_shadow), wb_dat_i, wb_sel_i));
                    REG_BRIGHTNESS: brightness_shadow <= PIXEL_WIDTH'(merge_lanes(
                        WB_DATA_WIDTH'(brightness_shadow), wb_dat_i, wb_sel_i));
                    REG_CTRL: begin
                        if (wb_sel_i[CTRL_BYPASS_BIT / 8]) begin
                            bypass_shadow <= wb_dat_i[CTRL_BYPASS_BIT];
                        end
                    end
                    // word 3 ignores writes
                    default: ;
                endcase
            end
        end
    end

    // readback shows the shadow copies
    always_ff @(posedge clk) begin
        if (req) begin
            case (reg_addr)
                REG_CONTRAST:   wb_dat_o <= WB_DATA_WIDTH'(contrast_shadow);
                REG_BRIGHTNESS: wb_dat_o <= WB_DATA_WIDTH'(brightness_shadow);
                REG_CTRL:       wb_dat_o <= WB_DATA_WIDTH'(bypass_shadow) << CTRL_BYPASS_BIT;
                default:        wb_dat_o <= '0;
            endcase
        end
    end

    // --------------------
    // frame-start update
    // --------------------

    // vs rise seen at edge N, active copy at N+1
    always_ff @(posedge clk) begin
        if (rst_i) begin
            vs_q         <= 1'b0;
            load_q       <= 1'b0;
            contrast_o   <= COE_WIDTH'(CONTRAST_RESET);
            brightness_o <= PIXEL_WIDTH'(BRIGHTNESS_RESET);
            bypass_o     <= 1'b0;
        end else begin
            vs_q   <= vs_i;
            load_q <= vs_i && !vs_q;
            if (load_q) begin
                contrast_o   <= contrast_shadow;
                brightness_o <= brightness_shadow;
                bypass_o     <= bypass_shadow;
            end
        end
    end

    // single-cycle ack pulse
    assert property (@(posedge clk) disable iff (rst_i) wb_ack_o |=> !wb_ack_o);

    // ack only answers a request from the cycle before
    assert property (@(posedge clk) disable iff (rst_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule

/* source/color_adjust_top.sv */
`timescale 1ns/10ps

module color_adjust_top
    import video_pkg::*;
    import csr_pkg::*;
#(
    parameter int PIXEL_WIDTH        = 8,
    parameter int COE_FRACTION_WIDTH = 6
) (
    input  logic                            clk,
    input  logic                            rst_i,
    // wishbone slave
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [WB_ADDR_WIDTH-1:0]        wb_adr_i,
    input  logic [WB_DATA_WIDTH-1:0]        wb_dat_i,
    input  logic [WB_DATA_WIDTH/8-1:0]      wb_sel_i,
    output logic [WB_DATA_WIDTH-1:0]        wb_dat_o,
    output logic                            wb_ack_o,
    // video in and out
    input  logic [CHANNELS*PIXEL_WIDTH-1:0] pix_i,
    input  logic                            de_i,
    input  logic                            hs_i,
    input  logic                            vs_i,
    output logic [CHANNELS*PIXEL_WIDTH-1:0] pix_o,
    output logic                            de_o,
    output logic                            hs_o,
    output logic                            vs_o
);

    logic [COE_WIDTH-1:0]   contrast;
    logic [PIXEL_WIDTH-1:0] brightness;
    logic                   bypass;

    adjust_csr #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) adjust_csr_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .vs_i         (vs_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .contrast_o   (contrast),
        .brightness_o (brightness),
        .bypass_o     (bypass)
    );

    color_adjust_pipe #(
        .PIXEL_WIDTH        (PIXEL_WIDTH),
        .COE_FRACTION_WIDTH (COE_FRACTION_WIDTH)
    ) color_adjust_pipe_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .pix_i        (pix_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .contrast_i   (contrast),
        .brightness_i (brightness),
        .bypass_i     (bypass),
        .pix_o        (pix_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

endmodule

/* tests/color_adjust_tb.sv */
`timescale 1ns/10ps

module color_adjust_tb
    import video_pkg::*;
    import csr_pkg::*;
();

    localparam int PIXEL_WIDTH        = 8;
    localparam int COE_FRACTION_WIDTH = 6;
    localparam int WORD_W             = CHANNELS * PIXEL_WIDTH;
    localparam int MID                = 1 << (PIXEL_WIDTH - 1);
    localparam int PIX_MAX            = (1 << PIXEL_WIDTH) - 1;
    localparam logic [WORD_W-1:0] DARK_MASK = {CHANNELS{PIXEL_WIDTH'('h3f)}};

    // frame shape
    localparam int VS_CYCLES    = 2;
    localparam int BLANK_CYCLES = 3;
    localparam int HS_CYCLES    = 2;
    localparam int LINES        = 4;
    localparam int LINE_PIXELS  = 16;
    localparam int TAIL_CYCLES  = 2;
    localparam int FRAME_CYCLES = VS_CYCLES + BLANK_CYCLES + TAIL_CYCLES
                                + LINES * (HS_CYCLES + LINE_PIXELS);
    localparam int NUM_FRAMES   = 11;
    localparam int DRAIN_LIMIT  = 4 * PIPE_LATENCY + 8;
    localparam int BUS_LIMIT    = 16;
    localparam int BUS_CYCLES   = 40 * 4;
    // four times the expected run length
    localparam int TIMEOUT_CYCLES = 4 * (NUM_FRAMES * (FRAME_CYCLES + DRAIN_LIMIT) + BUS_CYCLES);

    logic                       clk;
    logic                       rst_i;
    logic                       wb_cyc_i;
    logic                       wb_stb_i;
    logic                       wb_we_i;
    logic [WB_ADDR_WIDTH-1:0]   wb_adr_i;
    logic [WB_DATA_WIDTH-1:0]   wb_dat_i;
    logic [WB_DATA_WIDTH/8-1:0] wb_sel_i;
    logic [WB_DATA_WIDTH-1:0]   wb_dat_o;
    logic                       wb_ack_o;
    logic [WORD_W-1:0]          pix_i;
    logic                       de_i;
    logic                       hs_i;
    logic                       vs_i;
    logic [WORD_W-1:0]          pix_o;
    logic                       de_o;
    logic                       hs_o;
    logic                       vs_o;

    // register model and per-frame settings
    logic [COE_WIDTH-1:0]   sh_con = COE_WIDTH'(CONTRAST_RESET);
    logic [PIXEL_WIDTH-1:0] sh_bri = PIXEL_WIDTH'(BRIGHTNESS_RESET);
    logic                   sh_byp = 1'b0;
    int                     fr_con;
    int                     fr_bri;
    logic                   fr_byp;

    logic [15:0]       lfsr_state = 16'd54198;
    logic [WORD_W-1:0] exp_q [$];
    logic [2:0]        sync_hist [PIPE_LATENCY] = '{default: '0};
    string             test_name = "reset";
    int                cycle_count = 0;
    int                pixel_errors = 0;
    int                sync_errors = 0;
    int                reg_errors = 0;
    int                bus_errors = 0;

    color_adjust_top #(
        .PIXEL_WIDTH        (PIXEL_WIDTH),
        .COE_FRACTION_WIDTH (COE_FRACTION_WIDTH)
    ) color_adjust_top_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .pix_o    (pix_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // --------------------
    // helpers
    // --------------------

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // contrast*(p - mid) + mid + brightness, rounded and clamped
    function automatic logic [WORD_W-1:0] ref_adjust(input logic [WORD_W-1:0] pix,
                                                      input int con, input int bri);
        logic [WORD_W-1:0] res;
        int                p;
        int                v;
        for (int ch = int'(CH_R); ch <= int'(CH_B); ch++) begin
            p = int'(pix[ch*PIXEL_WIDTH +: PIXEL_WIDTH]);
            v = con * (p - MID) + ((MID + bri) << COE_FRACTION_WIDTH)
              + (1 << (COE_FRACTION_WIDTH - 1));
            if (v < 0) begin
                v = 0;
            end else begin
                v = v >> COE_FRACTION_WIDTH;
            end
            if (v > PIX_MAX) begin
                v = PIX_MAX;
            end
            res[ch*PIXEL_WIDTH +: PIXEL_WIDTH] = PIXEL_WIDTH'(v);
        end
        return res;
    endfunction

    function automatic void apply_write(input logic [1:0] word, input logic [31:0] data,
                                        input logic [3:0] sel);
        logic [31:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{sel[i]}};
        end
        case (word)
            REG_CONTRAST:   sh_con = COE_WIDTH'((32'(sh_con) & ~mask) | (data & mask));
            REG_BRIGHTNESS: sh_bri = PIXEL_WIDTH'((32'(sh_bri) & ~mask) | (data & mask));
            REG_CTRL:       sh_byp = sel[0] ? data[CTRL_BYPASS_BIT] : sh_byp;
            default: ;
        endcase
    endfunction

    // --------------------
    // wishbone master
    // --------------------

    task automatic bus_access(input logic we, input logic [1:0] word, input logic [31:0] wdata,
                              input logic [3:0] sel, output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= {word, 2'b00};
        wb_dat_i <= wdata;
        wb_sel_i <= sel;
        @(negedge clk);
        while (!wb_ack_o && waited < BUS_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (wb_ack_o) begin
            rdata = wb_dat_o;
            // request seen at the next edge, ack registered on that edge
            assert (waited == 1) else begin
                bus_errors++;
                $display("wishbone ack for word %0d came %0d cycles after the request",
                         word, waited);
            end
        end else begin
            bus_errors++;
            $display("wishbone access to word %0d never got an ack", word);
        end
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(negedge clk);
        assert (!wb_ack_o) else begin
            bus_errors++;
            $display("wishbone ack for word %0d lasted more than one cycle", word);
        end
    endtask

    task automatic wb_write(input logic [1:0] word, input logic [31:0] data,
                            input logic [3:0] sel);
        logic [31:0] unused;
        bus_access(1'b1, word, data, sel, unused);
        apply_write(word, data, sel);
    endtask

    task automatic check_read(input logic [1:0] word, input logic [31:0] expected);
        logic [31:0] actual;
        bus_access(1'b0, word, '0, 4'hf, actual);
        assert (actual == expected) else begin
            reg_errors++;
            $display("mismatch in %s: word %0d expected %h, actual %h",
                     test_name, word, expected, actual);
        end
    endtask

    task automatic set_settings(input logic [COE_WIDTH-1:0] con, input logic [PIXEL_WIDTH-1:0] bri);
        wb_write(REG_CONTRAST, 32'(con), 4'hf);
        wb_write(REG_BRIGHTNESS, 32'(bri), 4'hf);
    endtask

    // --------------------
    // video source
    // --------------------

    task automatic drive_cycle(input logic de, input logic hs, input logic vs,
                               input logic [WORD_W-1:0] pix);
        @(posedge clk);
        de_i  <= de;
        hs_i  <= hs;
        vs_i  <= vs;
        pix_i <= pix;
        if (de) begin
            exp_q.push_back(fr_byp ? pix : ref_adjust(pix, fr_con, fr_bri));
        end
    endtask

    task automatic drive_frame(input bit dark);
        logic [WORD_W-1:0] pix;
        // shadow values get loaded by this vs rise
        fr_con = int'(sh_con);
        fr_bri = int'(sh_bri);
        fr_byp = sh_byp;
        repeat (VS_CYCLES) drive_cycle(1'b0, 1'b0, 1'b1, '0);
        repeat (BLANK_CYCLES) drive_cycle(1'b0, 1'b0, 1'b0, '0);
        for (int line = 0; line < LINES; line++) begin
            repeat (HS_CYCLES) drive_cycle(1'b0, 1'b1, 1'b0, '0);
            for (int x = 0; x < LINE_PIXELS; x++) begin
                pix = WORD_W'(rand_bits(WORD_W));
                if (dark) begin
                    pix = pix & DARK_MASK;
                end
                drive_cycle(1'b1, 1'b0, 1'b0, pix);
            end
        end
        repeat (TAIL_CYCLES) drive_cycle(1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic drain_pipe();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        assert (exp_q.size() == 0) else begin
            pixel_errors++;
            $display("%s: %0d pixels never came out of the DUT", test_name, exp_q.size());
            exp_q.delete();
        end
    endtask

    // --------------------
    // comparator
    // --------------------

    always @(negedge clk) begin
        logic [WORD_W-1:0] expected;
        if (!rst_i) begin
            assert ({de_o, hs_o, vs_o} == sync_hist[PIPE_LATENCY-1]) else begin
                sync_errors++;
                $display("mismatch in %s: de/hs/vs expected %b, actual %b", test_name,
                         sync_hist[PIPE_LATENCY-1], {de_o, hs_o, vs_o});
            end
            if (de_o) begin
                if (exp_q.size() == 0) begin
                    pixel_errors++;
                    $display("%s: DUT put out a pixel that was never sent", test_name);
                end else begin
                    expected = exp_q.pop_front();
                    assert (pix_o == expected) else begin
                        pixel_errors++;
                        $display("mismatch in %s: pix_o expected %h, actual %h",
                                 test_name, expected, pix_o);
                    end
                end
            end
        end
        for (int i = PIPE_LATENCY - 1; i > 0; i--) begin
            sync_hist[i] = sync_hist[i-1];
        end
        sync_hist[0] = {de_i, hs_i, vs_i};
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // test sequence
    // --------------------

    initial begin
        rst_i    <= 1'b1;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        wb_adr_i <= '0;
        wb_dat_i <= '0;
        wb_sel_i <= '0;
        pix_i    <= '0;
        de_i     <= 1'b0;
        hs_i     <= 1'b0;
        vs_i     <= 1'b0;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;

        test_name = "registers";
        check_read(REG_CONTRAST, 32'd64);
        check_read(REG_BRIGHTNESS, 32'd0);
        check_read(REG_CTRL, 32'd0);
        check_read(2'd3, 32'd0);
        wb_write(REG_CONTRAST, 32'h0000_01ab, 4'b0001);
        check_read(REG_CONTRAST, 32'(sh_con));
        wb_write(REG_CONTRAST, 32'h0000_01ff, 4'b0010);
        check_read(REG_CONTRAST, 32'(sh_con));
        wb_write(REG_BRIGHTNESS, 32'hdead_be77, 4'b0001);
        wb_write(REG_BRIGHTNESS, 32'h0000_5500, 4'b0010);
        check_read(REG_BRIGHTNESS, 32'(sh_bri));
        wb_write(REG_CTRL, 32'h1, 4'hf);
        wb_write(REG_CTRL, 32'h0, 4'h0);
        check_read(REG_CTRL, 32'(sh_byp));
        wb_write(REG_CTRL, 32'h0, 4'b0001);
        check_read(REG_CTRL, 32'(sh_byp));
        wb_write(2'd3, 32'hffff_ffff, 4'hf);
        check_read(2'd3, 32'd0);
        set_settings(9'd64, 8'd0);

        test_name = "identity";
        drive_frame(1'b0);
        drain_pipe();

        // frame 0 hits the ceiling, 1 the floor, 2 has a small gain on dark input
        test_name = "random";
        for (int f = 0; f < 6; f++) begin
            case (f)
                0: set_settings(9'h100 | COE_WIDTH'(rand_bits(8)),
                                8'hc0 | PIXEL_WIDTH'(rand_bits(6)));
                1: set_settings(9'h0c0 | COE_WIDTH'(rand_bits(6)), 8'd0);
                2: set_settings(COE_WIDTH'(rand_bits(4)), PIXEL_WIDTH'(rand_bits(4)));
                default: set_settings(COE_WIDTH'(rand_bits(9)), PIXEL_WIDTH'(rand_bits(8)));
            endcase
            drive_frame(f == 1 || f == 2);
            drain_pipe();
        end

        test_name = "frame_update";
        set_settings(9'd96, 8'd10);
        fork
            drive_frame(1'b0);
            begin
                repeat (40) @(posedge clk);
                set_settings(9'd40, 8'd60);
            end
        join
        drive_frame(1'b0);
        drain_pipe();

        test_name = "bypass";
        wb_write(REG_CTRL, 32'h1, 4'hf);
        set_settings(COE_WIDTH'(rand_bits(9)), PIXEL_WIDTH'(rand_bits(8)));
        drive_frame(1'b0);
        wb_write(REG_CTRL, 32'h0, 4'hf);
        drive_frame(1'b0);
        drain_pipe();

        $display("error counts: pixel %0d, sync %0d, register %0d, bus %0d",
                 pixel_errors, sync_errors, reg_errors, bus_errors);
        if (pixel_errors + sync_errors + reg_errors + bus_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim.f */
source/video_pkg.sv
source/csr_pkg.sv
source/channel_contrast.sv
source/color_adjust_pipe.sv
source/adjust_csr.sv
source/color_adjust_top.sv
tests/color_adjust_tb.sv

/* Makefile */
# Verilator build and run for the colour-adjust testbench

VERILATOR ?= verilator
TOP       ?= color_adjust_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
